//--- bench/trk_main_asserts.sv
/*
 * Track main board checker
 * Reference models of the memory map, cabinet rows, NVRAM and output latch,
 * compared with the board by concurrent assertions
 */
`timescale 1ns/10ps

module trk_main_asserts (
    input logic        clk, rst, cpu_cen, cpu_rnw, cpu_vma, service,
    input logic        dip_pause, lvbl, ioctl_ram, ioctl_wr, irq_n, flip, snd_irq,
    input logic        rom_cs, vram_cs, objram_cs, nv_cs, snd_data_cs, iow_cs,
    input logic [15:0] cpu_addr, ioctl_addr,
    input logic [7:0]  cpu_dout, rom_data, vram_dout, obj_dout, dipsw_a, dipsw_b,
    input logic [7:0]  ioctl_dout, cpu_din, ioctl_din,
    input logic [3:0]  start_button,
    input logic [1:0]  coin_input,
    input logic [6:0]  joystick1, joystick2, joystick3, joystick4
);
    import trk_pkg::*;

    int          errs = 0;            // Read by the testbench at the end
    bus_region_e reg_x;
    logic [7:0]  shadow [2048];       // NVRAM contents as the bus should see them
    logic [7:0]  row_x, exp_din, exp_ioc;
    logic [5:0]  sel_x;
    logic [17:0] bus_d1, bus_d2;      // Bus history for held reads
    logic [15:0] ioc_d1;
    logic        wr_d1, held;
    logic        m_flip, m_snd, m_clrn, m_pend, m_dly, trig;

    // Memory map straight from the address table
    function automatic bus_region_e region_of(input logic [15:0] a, input logic rnw,
                                              input logic vma);
        logic io;
        io = a[15:14] == 2'b00 && a[13:11] == 3'd2 && !a[10];
        region_of = REG_NONE;
        if (!vma) region_of = REG_NONE;
        else if (rnw && a[15:13] >= 3'd3) region_of = REG_ROM;
        else if (a[15:14] == 2'b00 && a[13:11] == 3'd3) region_of = REG_OBJ;
        else if (a[15:14] == 2'b00 && a[13:11] == 3'd5) region_of = REG_NVRAM;
        else if (a[15:14] == 2'b00 && a[13:12] == 2'b11) region_of = REG_VRAM;
        else if (io && a[9:7] == 3'd1 && !rnw) region_of = REG_IOW;
        else if (io && a[9:7] == 3'd2 && !rnw) region_of = REG_SND;
        else if (io && a[9:7] == 3'd4) region_of = REG_IN5;
        else if (io && a[9:7] == 3'd5) region_of = REG_IOR;
    endfunction

    // Direction field bits 6-4 come out in reverse order
    function automatic logic [2:0] dir_rev(input logic [6:0] j);
        for (int i = 0; i < 3; i++) dir_rev[i] = j[6-i];
    endfunction

    initial begin
        for (int i = 0; i < 2048; i++) shadow[i] = 8'h00;
    end

    always_comb begin
        reg_x = region_of(cpu_addr, cpu_rnw, cpu_vma);
        sel_x = {reg_x == REG_ROM, reg_x == REG_VRAM, reg_x == REG_OBJ,
                 reg_x == REG_NVRAM, reg_x == REG_SND, reg_x == REG_IOW};
        case (cab_row_e'(cpu_addr[1:0]))
            CAB_COINS: row_x = {3'b111, start_button[1:0], service, coin_input};
            CAB_P12:   row_x = {1'b1, dir_rev(joystick2), start_button[2], dir_rev(joystick1)};
            CAB_P34:   row_x = {1'b1, dir_rev(joystick4), start_button[3], dir_rev(joystick3)};
            default:   row_x = dipsw_a;
        endcase
        case (reg_x)
            REG_ROM:   exp_din = rom_data;
            REG_VRAM:  exp_din = vram_dout;
            REG_NVRAM: exp_din = shadow[cpu_addr[10:0]];
            REG_OBJ:   exp_din = obj_dout;
            REG_IOR:   exp_din = row_x;
            REG_IN5:   exp_din = dipsw_b;
            default:   exp_din = 8'hFF;
        endcase
        if (!cpu_rnw) exp_din = 8'hFF;       // Writes read open bus
        exp_ioc = shadow[ioctl_addr[10:0]];
        trig = !lvbl && dip_pause;
        held = {cpu_vma, cpu_rnw, cpu_addr} == bus_d1 && bus_d1 == bus_d2;
    end

    always_ff @(posedge clk) begin
        bus_d1 <= {cpu_vma, cpu_rnw, cpu_addr};
        bus_d2 <= bus_d1;
        ioc_d1 <= ioctl_addr;
        wr_d1  <= (cpu_cen && reg_x == REG_NVRAM && !cpu_rnw) || (ioctl_ram && ioctl_wr);
        if (cpu_cen && reg_x == REG_NVRAM && !cpu_rnw) shadow[cpu_addr[10:0]] <= cpu_dout;
        if (ioctl_ram && ioctl_wr && ioctl_addr[15:11] == 5'd0) begin
            shadow[ioctl_addr[10:0]] <= ioctl_dout;   // Loader wins a collision
        end
    end

    // Latch and IRQ flip-flop model
    always_ff @(posedge clk) begin
        if (rst) begin
            {m_flip, m_snd, m_clrn, m_pend, m_dly} <= 5'b0;
        end else begin
            if (cpu_cen && reg_x == REG_IOW) begin
                case (latch_bit_e'(cpu_addr[2:0]))
                    LAT_FLIP:   m_flip <= cpu_dout[0];
                    LAT_SNDIRQ: m_snd  <= cpu_dout[0];
                    LAT_IRQCLR: m_clrn <= cpu_dout[0];
                    default: ;
                endcase
            end
            m_dly <= trig;
            if (!m_clrn) m_pend <= 1'b0;
            else if (trig && !m_dly) m_pend <= 1'b1;
        end
    end

    a_decode: assert property (@(posedge clk) disable iff (rst)
        {rom_cs, vram_cs, objram_cs, nv_cs, snd_data_cs, iow_cs} == sel_x)
        else begin
            errs = errs + 1;
            $error("FAIL %0t: chip selects for %h", $time, cpu_addr);
        end
    a_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, vram_cs, objram_cs, nv_cs, snd_data_cs, iow_cs}))
        else begin
            errs = errs + 1;
            $error("FAIL %0t: two chip selects high", $time);
        end
    a_read: assert property (@(posedge clk) disable iff (rst) held |-> cpu_din == exp_din)
        else begin
            errs = errs + 1;
            $error("FAIL %0t: cpu_din at %h", $time, cpu_addr);
        end
    a_loader: assert property (@(posedge clk) disable iff (rst)
        (ioctl_addr == ioc_d1 && !wr_d1) |-> ioctl_din == exp_ioc)
        else begin
            errs = errs + 1;
            $error("FAIL %0t: ioctl_din at %h", $time, ioctl_addr);
        end
    a_latch: assert property (@(posedge clk) flip == m_flip && snd_irq == m_snd)
        else begin
            errs = errs + 1;
            $error("FAIL %0t: output latch bits", $time);
        end
    a_irq: assert property (@(posedge clk) irq_n == !(m_pend && m_clrn))
        else begin
            errs = errs + 1;
            $error("FAIL %0t: irq_n level", $time);
        end
    a_vblank: assert property (@(posedge clk) disable iff (rst)
        ($fell(lvbl) && dip_pause && m_clrn) |=> !irq_n)
        else begin
            errs = errs + 1;
            $error("FAIL %0t: no IRQ after vblank", $time);
        end

endmodule

bind trk_main trk_main_asserts u_chk (.*);

//--- bench/trk_main_tb.sv
/*
 * Track main board testbench
 * Plays the CPU bus master and the NVRAM loader, models ROM and video memories
 */
`timescale 1ns/10ps
`include "trk_defines.svh"

module trk_main_tb;
    localparam int N_RAND = 300;
    localparam int N_ACC  = N_RAND + 40;     // Random plus directed accesses

    logic clk, rst, cpu_cen, cpu_rnw, cpu_vma, service, dip_pause, lvbl;
    logic ioctl_ram, ioctl_wr, irq_n, rom_cs, vram_cs, objram_cs, snd_data_cs;
    logic flip, snd_irq;
    logic [`TRK_AW-1:0] cpu_addr, ioctl_addr;
    logic [`TRK_DW-1:0] cpu_dout, rom_data, vram_dout, obj_dout, dipsw_a, dipsw_b;
    logic [`TRK_DW-1:0] ioctl_dout, cpu_din, ioctl_din;
    logic [3:0]  start_button;
    logic [1:0]  coin_input;
    logic [6:0]  joystick1, joystick2, joystick3, joystick4;
    logic [15:0] lfsr = 16'd93;
    logic [15:0] a, c, d;
    int          n_acc = 0;

    // Memory models, each byte depends on the whole address
    assign rom_data  = cpu_addr[15:8] ^ {cpu_addr[6:0], cpu_addr[7]};
    assign vram_dout = cpu_addr[7:0] + cpu_addr[15:8] + 8'h35;
    assign obj_dout  = ~(cpu_addr[7:0] ^ {cpu_addr[11:8], cpu_addr[15:12]});

    trk_main DUT (.*);

    // Taps 16,14,13,11, one step per bit
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic shuffle_inputs();
        logic [15:0] v;
        v = take_bits(7);
        joystick1 <= v[6:0];
        v = take_bits(7);
        joystick2 <= v[6:0];
        v = take_bits(7);
        joystick3 <= v[6:0];
        v = take_bits(7);
        joystick4 <= v[6:0];
        v = take_bits(7);
        {start_button, coin_input, service} <= v[6:0];
        v = take_bits(16);
        {dipsw_a, dipsw_b} <= v;
    endtask

    // One CPU access held for 3 cycles, cen in the middle one
    task automatic bus_access(input logic [15:0] addr, input logic rnw, input logic vma,
                              input logic [7:0] data, input logic cen);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_rnw  <= rnw;
        cpu_vma  <= vma;
        cpu_dout <= data;
        shuffle_inputs();                    // Cabinet and DIP inputs move with the address
        @(posedge clk);
        cpu_cen <= cen;
        @(posedge clk);
        cpu_cen <= 1'b0;
        n_acc++;
    endtask

    task automatic loader_access(input logic [15:0] addr, input logic wr, input logic [7:0] data);
        @(posedge clk);
        ioctl_addr <= addr;
        ioctl_ram  <= 1'b1;
        ioctl_wr   <= wr;                    // Single cycle pulse
        ioctl_dout <= data;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(posedge clk);
        ioctl_ram <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(N_ACC * 3 * 8 + 2000);
        $display("Watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        cpu_cen = 1'b0;
        cpu_rnw = 1'b1;
        cpu_vma = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        {start_button, coin_input, service} = '0;
        {joystick1, joystick2, joystick3, joystick4} = '0;
        {dipsw_a, dipsw_b} = '0;
        dip_pause = 1'b1;
        lvbl = 1'b1;
        ioctl_addr = '0;
        ioctl_ram = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_dout = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < N_RAND; i++) begin
            a = take_bits(16);
            c = take_bits(4);
            d = take_bits(8);
            bus_access(a, c[0], c[1] | c[2], d[7:0], c[3]);
        end
        for (int r = 0; r < 4; r++) begin
            bus_access(16'h1280 + 16'(r), 1'b1, 1'b1, 8'h00, 1'b0);   // Cabinet rows
        end
        bus_access(16'h1200, 1'b1, 1'b1, 8'h00, 1'b0);                // DIP bank B
        bus_access(16'h1280, 1'b0, 1'b1, 8'h00, 1'b0);                // Write reads FF
        bus_access(16'h1100, 1'b0, 1'b1, 8'h5A, 1'b1);                // Sound latch
        bus_access(16'h1100, 1'b1, 1'b1, 8'h00, 1'b0);                // Read, no select
        // NVRAM through both ports
        bus_access(16'h2812, 1'b0, 1'b1, 8'hA5, 1'b1);
        loader_access(16'h0012, 1'b0, 8'h00);
        loader_access(16'h0345, 1'b1, 8'h3C);
        bus_access(16'h2B45, 1'b1, 1'b1, 8'h00, 1'b0);
        loader_access(16'h1345, 1'b1, 8'hC3);                          // Outside the window
        bus_access(16'h2B45, 1'b1, 1'b1, 8'h00, 1'b0);
        // Output latch
        bus_access(16'h1080, 1'b0, 1'b1, 8'h01, 1'b1);
        bus_access(16'h1081, 1'b0, 1'b1, 8'h01, 1'b1);
        bus_access(16'h1080, 1'b0, 1'b1, 8'h00, 1'b0);                // No cen
        bus_access(16'h1083, 1'b0, 1'b1, 8'h00, 1'b1);
        bus_access(16'h1087, 1'b0, 1'b1, 8'h01, 1'b1);                // IRQ enabled
        // Vblank IRQ, then release and pause
        @(posedge clk) lvbl <= 1'b0;
        repeat (4) @(posedge clk);
        lvbl <= 1'b1;
        bus_access(16'h1087, 1'b0, 1'b1, 8'h00, 1'b1);
        bus_access(16'h1087, 1'b0, 1'b1, 8'h01, 1'b1);
        dip_pause <= 1'b0;
        @(posedge clk) lvbl <= 1'b0;
        repeat (4) @(posedge clk);
        lvbl <= 1'b1;
        repeat (2) @(posedge clk);
        $display("Accesses %0d, assertion errors %0d", n_acc, DUT.u_chk.errs);
        if (DUT.u_chk.errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- cabinet/trk_cabinet.sv
/*
 * Track cabinet inputs
 * Registered row multiplexer for coins, starts, joysticks and DIP bank A
 * Joystick direction bits come in reversed order on the board harness
 */
`timescale 1ns/10ps
`include "trk_defines.svh"

module trk_cabinet (
    input  logic               clk,
    input  logic [1:0]         addr_lo,       // CPU A1-A0
    input  logic [3:0]         start_button,
    input  logic [1:0]         coin_input,
    input  logic               service,
    input  logic [6:0]         joystick1,
    input  logic [6:0]         joystick2,
    input  logic [6:0]         joystick3,
    input  logic [6:0]         joystick4,
    input  logic [`TRK_DW-1:0] dipsw_a,
    output logic [`TRK_DW-1:0] cab_row        // To the read mux
);
    import trk_pkg::*;

    cab_row_e row_sel;

    // Swap bit 2 and bit 0 of a 3-bit field
    function automatic logic [2:0] rev3(input logic [2:0] x);
        rev3 = {x[0], x[1], x[2]};
    endfunction

    assign row_sel = cab_row_e'(addr_lo);

    // One cycle from address to row
    always_ff @(posedge clk) begin
        case (row_sel)
            CAB_COINS: begin
                cab_row <= {3'b111, start_button[1:0], service, coin_input[1:0]};
            end
            CAB_P12: begin
                cab_row <= {1'b1, rev3(joystick2[6:4]),   // Player 2 directions
                            start_button[2],
                            rev3(joystick1[6:4])};        // Player 1 directions
            end
            CAB_P34: begin
                cab_row <= {1'b1, rev3(joystick4[6:4]),
                            start_button[3],
                            rev3(joystick3[6:4])};
            end
            CAB_DIPA: begin
                cab_row <= dipsw_a;                       // Straight through
            end
            default: begin
                cab_row <= '1;
            end
        endcase
    end

endmodule

//--- common/trk_defines.svh
/*
 * Track main board glue logic
 * Bus widths and NVRAM geometry shared by every RTL block
 */
`ifndef TRK_DEFINES_SVH
`define TRK_DEFINES_SVH

// CPU bus, Konami style 6809 with 64 kB map
`define TRK_AW 16
`define TRK_DW 8

// NVRAM is 2 kB at 0x2800
`define TRK_NV_AW 11
`define TRK_NV_DEPTH (1 << `TRK_NV_AW)

// Loader bits above the NVRAM window, all must be zero
// to hit the NVRAM from ioctl
`define TRK_NV_LOADER_TOP 5

`endif

//--- common/trk_pkg.sv
/*
 * Track main board types
 * Bus regions, cabinet input rows and output latch bit numbers
 */
package trk_pkg;

    // Decoded region of the access on the CPU bus
    typedef enum logic [3:0] {
        REG_NONE,       // Open bus, reads 0xFF
        REG_ROM,        // 6000-FFFF, reads only
        REG_VRAM,       // 3000-3FFF
        REG_OBJ,        // 1800-1FFF
        REG_NVRAM,      // 2800-2FFF
        REG_IOR,        // Cabinet rows
        REG_IN5,        // DIP bank B
        REG_IOW,        // 74LS259 output latch
        REG_SND         // Sound latch
    } bus_region_e;

    // Cabinet row picked by A1-A0
    typedef enum logic [1:0] {
        CAB_COINS = 2'd0,
        CAB_P12   = 2'd1,
        CAB_P34   = 2'd2,
        CAB_DIPA  = 2'd3
    } cab_row_e;

    // Output latch bits picked by A2-A0, the others are unused on the board
    typedef enum logic [2:0] {
        LAT_FLIP   = 3'd0,
        LAT_SNDIRQ = 3'd1,
        LAT_IRQCLR = 3'd7
    } latch_bit_e;

endpackage

//--- list.f
+incdir+common
common/trk_pkg.sv
cabinet/trk_cabinet.sv
src/trk_bus_ctrl.sv
src/trk_nvram.sv
src/trk_io_latch.sv
src/trk_main.sv
bench/trk_main_asserts.sv
bench/trk_main_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the trk_main regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module trk_main_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtrk_main_tb +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

//--- src/trk_bus_ctrl.sv
/*
 * Track bus controller
 * Decodes the CPU memory map into chip selects and registers
 * the CPU read data multiplexer, open bus reads 0xFF
 */
`timescale 1ns/10ps
`include "trk_defines.svh"

module trk_bus_ctrl (
    input  logic               clk,
    input  logic [`TRK_AW-1:0] cpu_addr,
    input  logic               cpu_rnw,       // High for reads
    input  logic               cpu_vma,       // Valid memory address
    input  logic [`TRK_DW-1:0] rom_data,
    input  logic [`TRK_DW-1:0] vram_dout,
    input  logic [`TRK_DW-1:0] obj_dout,
    input  logic [`TRK_DW-1:0] nv_dout,
    input  logic [`TRK_DW-1:0] cab_row,
    input  logic [`TRK_DW-1:0] dipsw_b,
    output logic               rom_cs,
    output logic               vram_cs,
    output logic               objram_cs,
    output logic               nv_cs,
    output logic               snd_data_cs,
    output logic               iow_cs,        // Write qualified
    output logic [`TRK_DW-1:0] cpu_din
);
    import trk_pkg::*;

    bus_region_e region;

    // Memory map, mirrors the TTL decoders on the board
    always_comb begin
        region = REG_NONE;
        if (cpu_vma) begin
            if (cpu_rnw && cpu_addr[15:13] >= 3'd3) begin
                region = REG_ROM;                 // 6000-FFFF
            end else if (cpu_addr[15:14] == 2'b00) begin
                case (cpu_addr[13:11])            // First 3-to-8 decoder
                    3'd2: begin
                        if (!cpu_addr[10]) begin
                            case (cpu_addr[9:7])  // Second decoder for I/O
                                3'd1: begin
                                    if (!cpu_rnw) region = REG_IOW;
                                end
                                3'd2: begin
                                    if (!cpu_rnw) region = REG_SND;
                                end
                                3'd4: region = REG_IN5;
                                3'd5: region = REG_IOR;
                                default: ;        // AFE and spare strobes
                            endcase
                        end
                    end
                    3'd3:       region = REG_OBJ;   // Both object banks
                    3'd5:       region = REG_NVRAM;
                    3'd6, 3'd7: region = REG_VRAM;  // Tile codes and attributes
                    default: ;
                endcase
            end
        end
    end

    // One-hot selects, same cycle as the address
    assign rom_cs      = region == REG_ROM;
    assign vram_cs     = region == REG_VRAM;
    assign objram_cs   = region == REG_OBJ;
    assign nv_cs       = region == REG_NVRAM;
    assign snd_data_cs = region == REG_SND;
    assign iow_cs      = region == REG_IOW;

    // Read mux, one cycle after the sources settle
    always_ff @(posedge clk) begin
        if (!cpu_rnw) begin
            cpu_din <= '1;                        // Nothing to read on writes
        end else begin
            case (region)
                REG_ROM:   cpu_din <= rom_data;
                REG_VRAM:  cpu_din <= vram_dout;
                REG_NVRAM: cpu_din <= nv_dout;
                REG_OBJ:   cpu_din <= obj_dout;
                REG_IOR:   cpu_din <= cab_row;    // Row already registered
                REG_IN5:   cpu_din <= dipsw_b;
                default:   cpu_din <= '1;         // Open bus
            endcase
        end
    end

endmodule

//--- src/trk_io_latch.sv
/*
 * Track output latch and vblank interrupt
 * 74LS259 style addressable latch for flip, sound IRQ and IRQ clear,
 * plus the edge triggered IRQ flip-flop fed by vertical blank
 */
`timescale 1ns/10ps

module trk_io_latch (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_cen,
    input  logic       iow_cs,      // Already qualified by write
    input  logic [2:0] addr_lo,     // CPU A2-A0
    input  logic       data_bit,    // CPU D0
    input  logic       lvbl,        // Low during vertical blank
    input  logic       dip_pause,   // Low freezes the game
    output logic       flip,
    output logic       snd_irq,
    output logic       irq_n
);
    import trk_pkg::*;

    latch_bit_e lat_sel;

    logic irq_clrn;     // Latch bit 7
    logic irq_trig;
    logic trig_dly;
    logic irq_q;        // Pending interrupt

    assign lat_sel = latch_bit_e'(addr_lo);

    // Addressable latch, only three outputs wired on the board
    always_ff @(posedge clk) begin
        if (rst) begin
            flip     <= 1'b0;
            snd_irq  <= 1'b0;
            irq_clrn <= 1'b0;   // IRQ held off until the game enables it
        end else if (cpu_cen && iow_cs) begin
            case (lat_sel)
                LAT_FLIP:   flip     <= data_bit;
                LAT_SNDIRQ: snd_irq  <= data_bit;   // Level to the sound CPU
                LAT_IRQCLR: irq_clrn <= data_bit;
                default: ;                          // Coin counters and spares
            endcase
        end
    end

    // Vblank trigger, masked by pause
    assign irq_trig = ~lvbl & dip_pause;

    always_ff @(posedge clk) begin
        if (rst) begin
            trig_dly <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            trig_dly <= irq_trig;               // Edge detector
            if (!irq_clrn) begin
                irq_q <= 1'b0;                  // Clear wins over a new edge
            end else if (irq_trig && !trig_dly) begin
                irq_q <= 1'b1;
            end
        end
    end

    // Clear acts at once, like the CLR pin of the original FF
    assign irq_n = ~(irq_q & irq_clrn);

endmodule

//--- src/trk_main.sv
/*
 * Track main board glue
 * Ties the cabinet inputs, bus decoder, NVRAM and output latch
 * around the external CPU bus
 */
`timescale 1ns/10ps
`include "trk_defines.svh"

module trk_main (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_cen,
    input  logic [`TRK_AW-1:0] cpu_addr,
    input  logic               cpu_rnw,
    input  logic               cpu_vma,
    input  logic [`TRK_DW-1:0] cpu_dout,
    input  logic [`TRK_DW-1:0] rom_data,
    input  logic [`TRK_DW-1:0] vram_dout,
    input  logic [`TRK_DW-1:0] obj_dout,
    input  logic [3:0]         start_button,
    input  logic [1:0]         coin_input,
    input  logic               service,
    input  logic [6:0]         joystick1,
    input  logic [6:0]         joystick2,
    input  logic [6:0]         joystick3,
    input  logic [6:0]         joystick4,
    input  logic [`TRK_DW-1:0] dipsw_a,
    input  logic [`TRK_DW-1:0] dipsw_b,
    input  logic               dip_pause,
    input  logic               lvbl,
    input  logic [`TRK_AW-1:0] ioctl_addr,
    input  logic               ioctl_ram,
    input  logic               ioctl_wr,
    input  logic [`TRK_DW-1:0] ioctl_dout,
    output logic [`TRK_DW-1:0] cpu_din,
    output logic               irq_n,
    output logic               rom_cs,
    output logic               vram_cs,
    output logic               objram_cs,
    output logic               snd_data_cs,
    output logic               flip,
    output logic               snd_irq,
    output logic [`TRK_DW-1:0] ioctl_din
);

    logic [`TRK_DW-1:0] cab_row;
    logic [`TRK_DW-1:0] nv_dout;
    logic               nv_cs;
    logic               iow_cs;

    trk_cabinet u_cabinet (
        .clk(clk), .addr_lo(cpu_addr[1:0]), .start_button(start_button),
        .coin_input(coin_input), .service(service),
        .joystick1(joystick1), .joystick2(joystick2),
        .joystick3(joystick3), .joystick4(joystick4),
        .dipsw_a(dipsw_a), .cab_row(cab_row)
    );

    trk_bus_ctrl u_bus (
        .clk(clk), .cpu_addr(cpu_addr), .cpu_rnw(cpu_rnw), .cpu_vma(cpu_vma),
        .rom_data(rom_data), .vram_dout(vram_dout), .obj_dout(obj_dout),
        .nv_dout(nv_dout), .cab_row(cab_row), .dipsw_b(dipsw_b),
        .rom_cs(rom_cs), .vram_cs(vram_cs), .objram_cs(objram_cs),
        .nv_cs(nv_cs), .snd_data_cs(snd_data_cs), .iow_cs(iow_cs),
        .cpu_din(cpu_din)
    );

    // NVRAM window is the low 11 address bits
    trk_nvram u_nvram (
        .clk(clk), .cpu_cen(cpu_cen), .nv_cs(nv_cs), .cpu_rnw(cpu_rnw),
        .cpu_addr_lo(cpu_addr[`TRK_NV_AW-1:0]), .cpu_dout(cpu_dout),
        .ioctl_addr(ioctl_addr), .ioctl_ram(ioctl_ram), .ioctl_wr(ioctl_wr),
        .ioctl_dout(ioctl_dout), .nv_dout(nv_dout), .ioctl_din(ioctl_din)
    );

    trk_io_latch u_latch (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen), .iow_cs(iow_cs),
        .addr_lo(cpu_addr[2:0]), .data_bit(cpu_dout[0]),   // Latch D input is D0
        .lvbl(lvbl), .dip_pause(dip_pause),
        .flip(flip), .snd_irq(snd_irq), .irq_n(irq_n)
    );

endmodule

//--- src/trk_nvram.sv
/*
 * Track NVRAM
 * 2 kB dual-port RAM, one port for the CPU and one for the
 * loader that saves and restores the high score table
 */
`timescale 1ns/10ps
`include "trk_defines.svh"

module trk_nvram (
    input  logic                  clk,
    input  logic                  cpu_cen,
    input  logic                  nv_cs,
    input  logic                  cpu_rnw,
    input  logic [`TRK_NV_AW-1:0] cpu_addr_lo,
    input  logic [`TRK_DW-1:0]    cpu_dout,
    input  logic [`TRK_AW-1:0]    ioctl_addr,
    input  logic                  ioctl_ram,   // Loader is on the RAM section
    input  logic                  ioctl_wr,    // Write pulse
    input  logic [`TRK_DW-1:0]    ioctl_dout,
    output logic [`TRK_DW-1:0]    nv_dout,
    output logic [`TRK_DW-1:0]    ioctl_din
);

    logic [`TRK_DW-1:0] mem [`TRK_NV_DEPTH];

    logic cpu_we;
    logic ldr_we;
    logic ldr_hit;

    // Loader only reaches the NVRAM in the first 2 kB
    assign ldr_hit = ioctl_addr[`TRK_NV_AW +: `TRK_NV_LOADER_TOP] == '0;

    assign cpu_we = cpu_cen && nv_cs && !cpu_rnw;
    assign ldr_we = ioctl_ram && ioctl_wr && ldr_hit;

    // Writes from both sides
    // a same-address collision leaves the loader byte
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr_lo] <= cpu_dout;
        end
        if (ldr_we) begin
            mem[ioctl_addr[`TRK_NV_AW-1:0]] <= ioctl_dout;
        end
    end

    // Synchronous reads, old data on a write edge
    always_ff @(posedge clk) begin
        nv_dout   <= mem[cpu_addr_lo];
        ioctl_din <= mem[ioctl_addr[`TRK_NV_AW-1:0]];   // 1 cycle after address
    end

endmodule
